/* cpu_isa_pkg.sv */
package cpu_isa_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // operand offset, relative to base_addr_data
  typedef logic [7:0] offs_t;
  typedef logic [3:0] cmd_code_t;

  // command word layout, code in the top nibble
  // rsvd fills the word up to 32 bits
  typedef struct packed {
    cmd_code_t code;
    logic [3:0] rsvd;
    offs_t src1;
    offs_t src0;
    offs_t dst;
  } cmd_word_t;

  localparam cmd_code_t CMD_NOP = 4'd0;
  localparam cmd_code_t CMD_ADD = 4'd1;
  localparam cmd_code_t CMD_SUB = 4'd2;
  localparam cmd_code_t CMD_AND = 4'd3;
  localparam cmd_code_t CMD_OR = 4'd4;
  localparam cmd_code_t CMD_XOR = 4'd5;
  // src1 shifted left by src0[4:0]
  localparam cmd_code_t CMD_SHL = 4'd6;
  localparam cmd_code_t CMD_MOV = 4'd7;
  localparam cmd_code_t CMD_FORK = 4'd8;
  localparam cmd_code_t CMD_STOP = 4'd9;
  // 10..15 behave as nop

  // inter-core messages
  typedef logic [1:0] msg_kind_t;

  localparam msg_kind_t MSG_NONE = 2'd0;
  localparam msg_kind_t MSG_START = 2'd1;

  typedef struct packed {
    msg_kind_t kind;
    addr_t addr;
    logic pad;
  } cpu_msg_t;

endpackage

/* cpu_ctl_pkg.sv */
package cpu_ctl_pkg;

  import cpu_isa_pkg::*;

  // one pass per command
  // fetch -> s1 -> s0 -> exec/thread -> write/fetch/halt
  typedef enum logic [2:0] {
    ST_FETCH,
    ST_READ_S1,
    ST_READ_S0,
    ST_EXEC,
    ST_WRITE_D,
    ST_THREAD,
    ST_HALT
  } state_e;

  // both source operands as read from data memory
  typedef struct packed {
    data_t src1;
    data_t src0;
  } operands_t;

endpackage

/* state_sequencer.sv */
`timescale 1ns/1ns

module state_sequencer
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic clk_oe,
  input cmd_word_t command,
  input logic step_m,
  input logic step_a,
  input logic step_t,
  output state_e state
);

  // any sub-block finished its part of the state
  logic step_any;
  state_e state_nxt;
  logic is_thread;
  logic is_write;

  assign step_any = step_m | step_a | step_t;

  // fork and stop skip the alu
  assign is_thread = (command.code == CMD_FORK) || (command.code == CMD_STOP);

  // only real alu codes write back, nop and spare codes do not
  assign is_write = (command.code >= CMD_ADD) && (command.code <= CMD_MOV);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_FETCH: begin
        state_nxt = ST_READ_S1;
      end
      ST_READ_S1: begin
        state_nxt = ST_READ_S0;
      end
      ST_READ_S0: begin
        state_nxt = is_thread ? ST_THREAD : ST_EXEC;
      end
      ST_EXEC: begin
        state_nxt = is_write ? ST_WRITE_D : ST_FETCH;
      end
      ST_WRITE_D: begin
        state_nxt = ST_FETCH;
      end
      ST_THREAD: begin
        // stop parks the core, fork goes on
        state_nxt = (command.code == CMD_STOP) ? ST_HALT : ST_FETCH;
      end
      ST_HALT: begin
        // left only on step_t from an incoming start
        state_nxt = ST_FETCH;
      end
      default: begin
        state_nxt = ST_FETCH;
      end
    endcase
  end

  // step pulses are held by their blocks through clk_oe low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_FETCH;
    end else if (clk_oe && step_any) begin
      state <= state_nxt;
    end
  end

endmodule

/* mem_manager.sv */
`timescale 1ns/1ns

module mem_manager
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic clk_oe,
  input state_e state,
  input addr_t base_addr,
  input addr_t base_addr_data,
  input logic bus_busy,
  output logic read_q,
  output logic write_q,
  input logic read_dn,
  input logic write_dn,
  input addr_t addr_in,
  output addr_t addr_out,
  input data_t data_in,
  output data_t data_out,
  input data_t dst_in,
  input logic start_load,
  input addr_t start_addr,
  output cmd_word_t command,
  output operands_t operands,
  output logic step
);

  // instruction pointer, offset from base_addr
  addr_t ip;
  // held request address and write data
  addr_t addr_r;
  data_t data_r;
  addr_t req_addr;

  logic bus_st;
  logic req_on;
  logic raise;
  logic rd_hit;
  logic wr_hit;
  logic done_now;
  // done seen while clk_oe was low
  logic done_pend;
  logic done;

  assign bus_st = (state == ST_FETCH) || (state == ST_READ_S1)
               || (state == ST_READ_S0) || (state == ST_WRITE_D);
  assign req_on = read_q | write_q;

  // one request per bus state, never again once step is out
  assign raise = clk_oe && bus_st && !req_on && !step && !bus_busy;

  // read data only counts if the snooped address is ours
  assign rd_hit = read_q && read_dn && (addr_in == addr_r);
  assign wr_hit = write_q && write_dn;
  assign done_now = rd_hit | wr_hit;
  assign done = done_now | done_pend;

  // address of the access for the current state
  always_comb begin
    case (state)
      ST_READ_S1: req_addr = base_addr_data + addr_t'(command.src1);
      ST_READ_S0: req_addr = base_addr_data + addr_t'(command.src0);
      ST_WRITE_D: req_addr = base_addr_data + addr_t'(command.dst);
      default: req_addr = base_addr + ip;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_q <= 1'b0;
      write_q <= 1'b0;
      step <= 1'b0;
      done_pend <= 1'b0;
      ip <= '0;
    end else if (clk_oe) begin
      step <= 1'b0;
      done_pend <= 1'b0;
      // restart address from a start message
      if (start_load) begin
        ip <= start_addr;
      end
      if (req_on && done) begin
        // drop request, tell the sequencer
        read_q <= 1'b0;
        write_q <= 1'b0;
        step <= 1'b1;
        if (state == ST_FETCH) begin
          ip <= ip + addr_t'(1);
        end
      end else if (raise) begin
        read_q <= (state != ST_WRITE_D);
        write_q <= (state == ST_WRITE_D);
      end
    end else if (done_now) begin
      done_pend <= 1'b1;
    end
  end

  // address and write data latched when the request rises
  always_ff @(posedge clk) begin
    if (raise) begin
      addr_r <= req_addr;
      data_r <= dst_in;
    end
  end

  // read data taken whenever the done shows, enabled or not
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      case (state)
        ST_FETCH: command <= cmd_word_t'(data_in);
        ST_READ_S1: operands.src1 <= data_in;
        ST_READ_S0: operands.src0 <= data_in;
        default: ;
      endcase
    end
  end

  // bus outputs are zero between requests
  assign addr_out = req_on ? addr_r : '0;
  assign data_out = write_q ? data_r : '0;

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic clk_oe,
  input state_e state,
  input cmd_word_t command,
  input operands_t operands,
  output data_t dst_out,
  output logic step
);

  data_t result;
  logic calc;

  // one enabled cycle in exec, step blocks a second pass
  assign calc = clk_oe && (state == ST_EXEC) && !step;

  // all arithmetic wraps at 32 bits
  always_comb begin
    case (command.code)
      CMD_ADD: result = operands.src1 + operands.src0;
      CMD_SUB: result = operands.src1 - operands.src0;
      CMD_AND: result = operands.src1 & operands.src0;
      CMD_OR: result = operands.src1 | operands.src0;
      CMD_XOR: result = operands.src1 ^ operands.src0;
      // shift amount from low five bits only
      CMD_SHL: result = operands.src1 << operands.src0[4:0];
      CMD_MOV: result = operands.src1;
      // nop and spare codes, never written back
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= 1'b0;
    end else if (clk_oe) begin
      step <= calc;
    end
  end

  // result stays put through write_d
  always_ff @(posedge clk) begin
    if (calc) begin
      dst_out <= result;
    end
  end

endmodule

/* thread_ctl.sv */
`timescale 1ns/1ns

module thread_ctl
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic clk_oe,
  input state_e state,
  input cmd_word_t command,
  input operands_t operands,
  input cpu_msg_t cpu_msg_in,
  output cpu_msg_t cpu_msg_out,
  output logic cpu_msg_pulse,
  output addr_t addr_out,
  output data_t data_out,
  output logic start_load,
  output addr_t start_addr,
  output logic step
);

  // start message seen while halted
  logic start_hit;
  // start taken during a clk_oe low cycle
  logic start_pend;

  assign start_hit = (state == ST_HALT) && (cpu_msg_in.kind == MSG_START);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= 1'b0;
      cpu_msg_pulse <= 1'b0;
      cpu_msg_out <= '0;
      start_load <= 1'b0;
      start_pend <= 1'b0;
    end else if (clk_oe) begin
      step <= 1'b0;
      cpu_msg_pulse <= 1'b0;
      cpu_msg_out <= '0;
      start_load <= 1'b0;
      start_pend <= 1'b0;
      if ((state == ST_THREAD) && !step) begin
        step <= 1'b1;
        // fork hands src1 to the other core as its start offset
        if (command.code == CMD_FORK) begin
          cpu_msg_pulse <= 1'b1;
          cpu_msg_out.kind <= MSG_START;
          cpu_msg_out.addr <= operands.src1[ADDR_W-1:0];
        end
      end else if ((start_hit || start_pend) && !step) begin
        start_load <= 1'b1;
        step <= 1'b1;
      end
    end else if (start_hit && !step) begin
      start_pend <= 1'b1;
    end
  end

  // first start address wins until the restart is consumed
  always_ff @(posedge clk) begin
    if (start_hit && !step && !start_pend) begin
      start_addr <= cpu_msg_in.addr;
    end
  end

  // no bus cycles of its own here
  assign addr_out = '0;
  assign data_out = '0;

endmodule

/* internal_bus.sv */
`timescale 1ns/1ns

module internal_bus
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
(
  input logic clk,
  input logic clk_oe,
  input logic rst_n,
  input logic bus_busy,
  input addr_t base_addr,
  input addr_t base_addr_data,
  output cmd_word_t command,
  output state_e state,
  input addr_t addr_in,
  output addr_t addr_out,
  input data_t data_in,
  output data_t data_out,
  output logic read_q,
  output logic write_q,
  input logic read_dn,
  input logic write_dn,
  input cpu_msg_t cpu_msg_in,
  output cpu_msg_t cpu_msg_out,
  output logic cpu_msg_pulse
);

  // per-block bus outputs ored below
  addr_t addr_out_m;
  addr_t addr_out_t;
  data_t data_out_m;
  data_t data_out_t;

  logic step_m;
  logic step_a;
  logic step_t;

  operands_t operands;
  data_t dst;
  logic start_load;
  addr_t start_addr;

  // both blocks drive zero when they have no bus cycle
  assign addr_out = addr_out_m | addr_out_t;
  assign data_out = data_out_m | data_out_t;

  state_sequencer states_mng (
    .clk(clk), .rst_n(rst_n), .clk_oe(clk_oe),
    .command(command),
    .step_m(step_m), .step_a(step_a), .step_t(step_t),
    .state(state)
  );

  mem_manager mem_mng (
    .clk(clk), .rst_n(rst_n), .clk_oe(clk_oe),
    .state(state),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .bus_busy(bus_busy),
    .read_q(read_q), .write_q(write_q),
    .read_dn(read_dn), .write_dn(write_dn),
    .addr_in(addr_in), .addr_out(addr_out_m),
    .data_in(data_in), .data_out(data_out_m),
    .dst_in(dst),
    .start_load(start_load), .start_addr(start_addr),
    .command(command), .operands(operands),
    .step(step_m)
  );

  alu alu_1 (
    .clk(clk), .rst_n(rst_n), .clk_oe(clk_oe),
    .state(state), .command(command), .operands(operands),
    .dst_out(dst),
    .step(step_a)
  );

  thread_ctl thrd_1 (
    .clk(clk), .rst_n(rst_n), .clk_oe(clk_oe),
    .state(state), .command(command), .operands(operands),
    .cpu_msg_in(cpu_msg_in), .cpu_msg_out(cpu_msg_out),
    .cpu_msg_pulse(cpu_msg_pulse),
    .addr_out(addr_out_t), .data_out(data_out_t),
    .start_load(start_load), .start_addr(start_addr),
    .step(step_t)
  );

endmodule

/* tb_internal_bus.sv */
`timescale 1ns/1ns

module tb_internal_bus
  import cpu_isa_pkg::*;
  import cpu_ctl_pkg::*;
();

  // one predicted bus event tagged with its test
  typedef struct packed {
    logic [2:0] tag;
    logic [1:0] kind;
    addr_t addr;
    data_t data;
  } ev_t;

  localparam logic [1:0] EV_FETCH = 2'd0;
  localparam logic [1:0] EV_WRITE = 2'd1;
  localparam logic [1:0] EV_FORK = 2'd2;
  localparam addr_t BASE = 16'h1000;
  localparam addr_t BASE_D = 16'h8000;

  logic clk, rst_n, clk_oe, bus_busy, read_q, write_q, read_dn, write_dn, cpu_msg_pulse;
  addr_t base_addr, base_addr_data, addr_in, addr_out, prev_addr, restart;
  data_t data_in, data_out;
  cmd_word_t command;
  state_e state;
  cpu_msg_t cpu_msg_in, cpu_msg_out;

  logic [31:0] mem [0:65535];
  // data image for the reference executor
  data_t mdata [0:255];
  ev_t evq [$];
  int checks [1:6];
  int errs [1:6];
  int consumed, delay, total_c, total_e;
  logic prev_req, prev_busy, timed_out, seen;
  // fetched word still to be seen on command
  logic cmd_due;
  int cmd_tag;
  data_t cmd_exp;

  internal_bus uut (.*);

  always #10 clk = ~clk;

  task automatic check_val(input int tag, input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks[tag]++;
    assert (got === exp) else begin
      errs[tag]++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input int tag, input string msg);
    checks[tag]++;
    errs[tag]++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  task automatic match_event(input logic [1:0] kind, input addr_t addr, input data_t data);
    ev_t ev;
    assert (evq.size() != 0) else begin
      report_fail(3, "bus or message event appeared with nothing predicted");
    end
    if (evq.size() != 0) begin
      ev = evq.pop_front();
      consumed++;
      assert (ev.kind == kind) else begin
        report_fail(int'(ev.tag), $sformatf("event kind %0d seen, %0d predicted", kind, ev.kind));
      end
      if (ev.kind == kind) begin
        check_val(int'(ev.tag), "addr_out", 32'(addr), 32'(ev.addr));
        if (kind == EV_WRITE) begin
          check_val(int'(ev.tag), "data_out", data, ev.data);
        end
        // word is due on command once the sequencer moves on
        if (kind == EV_FETCH) begin
          cmd_exp = ev.data;
          cmd_tag = int'(ev.tag);
          cmd_due = 1'b1;
        end
      end
    end
  endtask

  function automatic data_t alu_model(input cmd_code_t code, input data_t a, input data_t b);
    case (code)
      CMD_ADD: return a + b;
      CMD_SUB: return a - b;
      CMD_AND: return a & b;
      CMD_OR: return a | b;
      CMD_XOR: return a ^ b;
      CMD_SHL: return a << b[4:0];
      default: return a;
    endcase
  endfunction

  function automatic logic [31:0] make_cmd(input cmd_code_t code);
    return {code, 4'h0, 8'($urandom), 8'($urandom), 8'($urandom)};
  endfunction

  // reference executor walking the program from ip up to a stop
  task automatic predict(input addr_t ip, input int force_tag);
    cmd_word_t w;
    int tag;
    data_t res;
    for (int n = 0; n < 1000; n++) begin
      w = cmd_word_t'(mem[BASE + ip]);
      if (force_tag != 0) tag = force_tag;
      else if (w.code >= CMD_ADD && w.code <= CMD_MOV) tag = 2;
      else if (w.code == CMD_FORK) tag = 4;
      else if (w.code == CMD_STOP) tag = 5;
      else tag = 6;
      evq.push_back({3'(tag), EV_FETCH, BASE + ip, data_t'(w)});
      if (w.code >= CMD_ADD && w.code <= CMD_MOV) begin
        res = alu_model(w.code, mdata[w.src1], mdata[w.src0]);
        mdata[w.dst] = res;
        evq.push_back({3'(tag), EV_WRITE, BASE_D + addr_t'(w.dst), res});
      end else if (w.code == CMD_FORK) begin
        evq.push_back({3'(tag), EV_FORK, mdata[w.src1][15:0], 32'h0});
      end
      if (w.code == CMD_STOP) break;
      ip = ip + 16'd1;
    end
  endtask

  function automatic logic pending(input int tag);
    foreach (evq[i]) begin
      if (int'(evq[i].tag) == tag) return 1'b1;
    end
    return 1'b0;
  endfunction

  // waits until no event of the tag is left
  // timer restarts on progress
  task automatic wait_gone(input int tag);
    int timer;
    int last;
    timer = 0;
    last = consumed;
    while (!timed_out && pending(tag)) begin
      @(posedge clk);
      if (consumed != last) begin
        last = consumed;
        timer = 0;
      end else begin
        timer++;
      end
      if (timer > 2000) begin
        timed_out = 1'b1;
        $display("timeout: test %0d stalled, %0d events outstanding", tag, evq.size());
      end
    end
  endtask

  task automatic wait_halt(input logic want);
    int timer;
    timer = 0;
    while (!timed_out && ((state == ST_HALT) != want)) begin
      @(posedge clk);
      timer++;
      if (timer > 2000) begin
        timed_out = 1'b1;
        if (want) begin
          $display("timeout: core did not halt");
        end else begin
          $display("timeout: core did not leave halt");
        end
      end
    end
  endtask

  // memory model, bus environment and protocol monitor
  always @(posedge clk) begin
    if (rst_n) begin
      check_val(3, "read_q&write_q", 32'(read_q & write_q), 32'h0);
      if ((read_q || write_q) && !prev_req) begin
        check_val(3, "bus_busy at request rise", 32'(prev_busy), 32'h0);
      end
      if ((read_q || write_q) && prev_req) begin
        check_val(3, "addr_out held", 32'(addr_out), 32'(prev_addr));
      end
      if (cmd_due && (state == ST_READ_S1)) begin
        check_val(cmd_tag, "command", 32'(command), cmd_exp);
        cmd_due = 1'b0;
      end
    end
    prev_req <= read_q | write_q;
    prev_busy <= bus_busy;
    prev_addr <= addr_out;
    bus_busy <= ($urandom % 10) < 3;
    clk_oe <= ($urandom % 10) < 8;
    addr_in <= addr_out;
    if (cpu_msg_pulse && clk_oe) begin
      check_val(4, "cpu_msg_out.kind", 32'(cpu_msg_out.kind), 32'(MSG_START));
      match_event(EV_FORK, cpu_msg_out.addr, 32'h0);
    end
    // done stays up until an enabled cycle has seen it
    if (read_dn || write_dn) begin
      if (clk_oe) begin
        read_dn <= 1'b0;
        write_dn <= 1'b0;
      end
    end else if (read_q || write_q) begin
      if (delay != 0) begin
        delay <= delay - 1;
      end else if (read_q) begin
        read_dn <= 1'b1;
        data_in <= mem[addr_out];
        if (state == ST_FETCH) match_event(EV_FETCH, addr_out, 32'h0);
      end else begin
        write_dn <= 1'b1;
        mem[addr_out] = data_out;
        match_event(EV_WRITE, addr_out, data_out);
      end
    end else begin
      delay <= int'($urandom % 6);
    end
  end

  initial begin
    void'($urandom(32'h7cd8_3789));
    {clk, clk_oe, bus_busy, read_dn, write_dn, prev_req, prev_busy, timed_out, cmd_due} = '0;
    rst_n = 1'b0;
    base_addr = BASE;
    base_addr_data = BASE_D;
    {addr_in, prev_addr, data_in, delay, consumed} = '0;
    cpu_msg_in = '0;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {16'(i) ^ 16'hc35a, 16'(i)};
    end
    for (int i = 0; i < 256; i++) begin
      mdata[i] = $urandom;
      mem[BASE_D + 16'(i)] = mdata[i];
    end
    // 300 alu then a fork and nop mix then stop
    for (int i = 0; i < 300; i++) mem[BASE + 16'(i)] = make_cmd(cmd_code_t'(1 + $urandom % 7));
    for (int i = 300; i < 340; i++) begin
      if ($urandom % 2 == 0) mem[BASE + 16'(i)] = make_cmd(CMD_FORK);
      else if ($urandom % 2 == 0) mem[BASE + 16'(i)] = make_cmd(CMD_NOP);
      else mem[BASE + 16'(i)] = make_cmd(cmd_code_t'(10 + $urandom % 6));
    end
    mem[BASE + 16'd340] = make_cmd(CMD_STOP);
    restart = 16'd400 + 16'($urandom % 400);
    for (int i = 0; i < 20; i++) begin
      mem[BASE + restart + 16'(i)] = make_cmd(cmd_code_t'($urandom % 8));
    end
    mem[BASE + restart + 16'd20] = make_cmd(CMD_STOP);
    predict(16'd0, 0);

    // test 1 covers reset and the first request
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      // outputs hold their reset value from the first reset edge on
      if (i > 0) begin
        check_val(1, "read_q", 32'(read_q), 32'h0);
        check_val(1, "write_q", 32'(write_q), 32'h0);
        check_val(1, "cpu_msg_pulse", 32'(cpu_msg_pulse), 32'h0);
      end
    end
    rst_n <= 1'b1;
    for (int t = 0; !(read_q || write_q); t++) begin
      @(posedge clk);
      check_val(1, "cpu_msg_pulse", 32'(cpu_msg_pulse), 32'h0);
      if (t > 2000) begin
        timed_out = 1'b1;
        $display("timeout: no first request after reset");
        break;
      end
    end
    check_val(1, "read_q", 32'(read_q), 32'h1);
    check_val(1, "addr_out", 32'(addr_out), 32'(BASE));
    $display("test 1 reset: %0d checks, %0d errors", checks[1], errs[1]);
    wait_gone(2);
    $display("test 2 alu: %0d checks, %0d errors", checks[2], errs[2]);
    wait_gone(4);
    $display("test 4 fork: %0d checks, %0d errors", checks[4], errs[4]);
    wait_gone(6);
    $display("test 6 nop: %0d checks, %0d errors", checks[6], errs[6]);

    // test 5 halts and stays silent before a restart by message
    wait_gone(5);
    wait_halt(1'b1);
    seen = 1'b0;
    for (int i = 0; i < 50; i++) begin
      @(posedge clk);
      seen = seen | read_q | write_q;
    end
    check_val(5, "read_q|write_q while halted", 32'(seen), 32'h0);
    predict(restart, 5);
    @(posedge clk);
    cpu_msg_in <= '{kind: MSG_START, addr: restart, pad: 1'b0};
    wait_halt(1'b0);
    cpu_msg_in <= '0;
    wait_gone(5);
    wait_halt(1'b1);
    $display("test 5 stop and restart: %0d checks, %0d errors", checks[5], errs[5]);
    $display("test 3 bus protocol: %0d checks, %0d errors", checks[3], errs[3]);
    total_c = 0;
    total_e = 0;
    for (int i = 1; i <= 6; i++) begin
      total_c += checks[i];
      total_e += errs[i];
    end
    $display("total: %0d checks, %0d errors", total_c, total_e);
    if (total_e == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
cpu_isa_pkg.sv
cpu_ctl_pkg.sv
state_sequencer.sv
mem_manager.sv
alu.sv
thread_ctl.sv
internal_bus.sv
tb_internal_bus.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_internal_bus -f vlog.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
